// File: Bender.yml
package:
  name: dbg_monitor

sources:
  - include_dirs:
      - source
    files:
      - source/dbg_probe_pkg.sv
      - source/dbg_video_pkg.sv
      - source/dbg_monitor_fsm.sv
      - source/dbg_scan_timer.sv
      - source/dbg_probe_bank.sv
      - source/dbg_led_select.sv
      - source/dbg_cell_render.sv
      - source/dbg_monitor_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_dbg_monitor.sv

// File: source/dbg_cell_render.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_cell_render
	import dbg_probe_pkg::*;
	import dbg_video_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   cell_tick,
	input  grid_row_t              scan_row,
	input  grid_col_t              scan_col,
	input  logic [`DBG_WORD_W-1:0] grid_word,
	output probe_idx_t             grid_idx,
	output logic                   cell_valid,
	output grid_row_t              cell_row,
	output grid_col_t              cell_col,
	output logic                   vga_space,
	output logic [3:0]             vga_data
);

	localparam int SLOT_W     = $clog2(`DBG_SLOTS_PER_ROW);
	localparam int PROBE_ROWS = `DBG_NUM_PROBES / `DBG_SLOTS_PER_ROW;
	localparam int PROW_W     = $clog2(PROBE_ROWS);

	logic [SLOT_W-1:0] slot;
	logic [1:0]        nib_sel;
	grid_row_t         probe_row;
	cell_kind_e        kind;
	logic [3:0]        nibble;

	////////////////////////////////////////////////////////////////////
	// Cell decode
	////////////////////////////////////////////////////////////////////

	// Eight columns per slot: four nibbles then four blanks
	assign slot    = scan_col[SLOT_W+2:3];
	assign nib_sel = scan_col[1:0];

	assign probe_row = scan_row - 1'b1;
	assign grid_idx  = probe_idx_t'({probe_row[PROW_W-1:0], slot});

	always_comb begin
		if (scan_col[2])
			kind = CELL_SPACE;
		else if (scan_row == '0)
			kind = CELL_HEADER;
		else if (scan_row <= grid_row_t'(PROBE_ROWS))
			kind = CELL_PROBE;
		else
			kind = CELL_SPACE;
	end

	// Nibble 0 is the top of the word
	always_comb begin
		case (kind)
			CELL_HEADER: nibble = (nib_sel == 2'd3) ? 4'(slot) : 4'h0;
			CELL_PROBE:  nibble = grid_word[`DBG_WORD_W-1 - 4*nib_sel -: 4];
			default:     nibble = 4'h0;
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cell_valid <= 1'b0;
			cell_row   <= '0;
			cell_col   <= '0;
			vga_space  <= 1'b0;
			vga_data   <= '0;
		end else begin
			cell_valid <= cell_tick;
			if (cell_tick) begin
				cell_row  <= scan_row;
				cell_col  <= scan_col;
				vga_space <= (kind == CELL_SPACE);
				vga_data  <= nibble;
			end
		end
	end

	a_space_blank: assert property (@(posedge clk) disable iff (!arst_n)
		vga_space |-> vga_data == '0);

	// Cells are spaced by the tick divider
	a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		cell_valid |=> !cell_valid);

endmodule

`default_nettype wire

// File: source/dbg_defines.svh
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// Probe words from the CPU
`define DBG_WORD_W        16
`define DBG_NUM_PROBES    64

// Character grid
`define DBG_GRID_COLS     128
`define DBG_GRID_ROWS     8
`define DBG_SLOTS_PER_ROW 16

// clk cycles per character cell
`define DBG_CELL_DIV      4

`endif

// File: source/dbg_led_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_led_select import dbg_probe_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [15:0]            sw,
	input  logic [`DBG_WORD_W-1:0] led_word,
	output probe_idx_t             led_idx,
	output logic [15:0]            led_data
);

	localparam logic [7:0] NUM_PAGES = 8'(`DBG_NUM_PROBES);

	logic [7:0]  page;
	logic        page_hit;
	logic [15:0] led_nxt;

	////////////////////////////////////////////////////////////////////
	// Page decode
	////////////////////////////////////////////////////////////////////

	assign page     = sw[15:8];
	assign page_hit = (page < NUM_PAGES);
	assign led_idx  = page[PROBE_IDX_W-1:0];

	// Pages past the last probe echo the switches
	always_comb begin
		if (page_hit)
			led_nxt = 16'(led_word);
		else
			led_nxt = sw;
	end

	////////////////////////////////////////////////////////////////////
	// LED register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			led_data <= '0;
		else
			led_data <= led_nxt;
	end

endmodule

`default_nettype wire

// File: source/dbg_monitor_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_monitor_fsm import dbg_probe_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic freeze,
	input  logic step,
	input  logic frame_start,
	output logic snap,
	output logic frozen
);

	monitor_state_e state;
	monitor_state_e state_nxt;

	////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			RUN: begin
				if (freeze)
					state_nxt = HOLD;
			end
			HOLD: begin
				// Releasing freeze wins over a step
				if (!freeze)
					state_nxt = RUN;
				else if (step)
					state_nxt = STEP_WAIT;
			end
			STEP_WAIT: begin
				if (frame_start)
					state_nxt = HOLD;
			end
			default: state_nxt = RUN;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= RUN;
			frozen <= 1'b0;
		end else begin
			state  <= state_nxt;
			frozen <= (state_nxt != RUN);
		end
	end

	// Snapshot on frame start, except while holding
	assign snap = frame_start && ((state == RUN) || (state == STEP_WAIT));

	// One-cycle strobe tied to the scan frame boundary
	a_snap_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(snap) |-> frame_start ##1 !snap);

endmodule

`default_nettype wire

// File: source/dbg_monitor_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_monitor_top
	import dbg_probe_pkg::*;
	import dbg_video_pkg::*;
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  logic [15:0]                                  sw,
	input  logic                                         freeze,
	input  logic                                         step,
	input  logic [`DBG_NUM_PROBES-1:0][`DBG_WORD_W-1:0] probe_word,
	output logic [15:0]                                  led_data,
	output logic                                         cell_valid,
	output grid_row_t                                    cell_row,
	output grid_col_t                                    cell_col,
	output logic                                         vga_space,
	output logic [3:0]                                   vga_data,
	output logic                                         frame_start,
	output logic                                         frozen
);

	logic                   cell_tick;
	grid_row_t              scan_row;
	grid_col_t              scan_col;
	logic                   snap;
	probe_idx_t             led_idx;
	probe_idx_t             grid_idx;
	logic [`DBG_WORD_W-1:0] led_word;
	logic [`DBG_WORD_W-1:0] grid_word;

	////////////////////////////////////////////////////////////////////
	// Scan and snapshot control
	////////////////////////////////////////////////////////////////////

	dbg_scan_timer scan_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.cell_tick   (cell_tick),
		.scan_row    (scan_row),
		.scan_col    (scan_col),
		.frame_start (frame_start)
	);

	dbg_monitor_fsm fsm_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.freeze      (freeze),
		.step        (step),
		.frame_start (frame_start),
		.snap        (snap),
		.frozen      (frozen)
	);

	dbg_probe_bank bank_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.snap       (snap),
		.probe_word (probe_word),
		.led_idx    (led_idx),
		.grid_idx   (grid_idx),
		.led_word   (led_word),
		.grid_word  (grid_word)
	);

	////////////////////////////////////////////////////////////////////
	// Display paths
	////////////////////////////////////////////////////////////////////

	dbg_led_select led_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.sw       (sw),
		.led_word (led_word),
		.led_idx  (led_idx),
		.led_data (led_data)
	);

	dbg_cell_render render_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.cell_tick  (cell_tick),
		.scan_row   (scan_row),
		.scan_col   (scan_col),
		.grid_word  (grid_word),
		.grid_idx   (grid_idx),
		.cell_valid (cell_valid),
		.cell_row   (cell_row),
		.cell_col   (cell_col),
		.vga_space  (vga_space),
		.vga_data   (vga_data)
	);

endmodule

`default_nettype wire

// File: source/dbg_probe_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_probe_bank import dbg_probe_pkg::*; (
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  logic                                         snap,
	input  logic [`DBG_NUM_PROBES-1:0][`DBG_WORD_W-1:0] probe_word,
	input  probe_idx_t                                   led_idx,
	input  probe_idx_t                                   grid_idx,
	output logic [`DBG_WORD_W-1:0]                       led_word,
	output logic [`DBG_WORD_W-1:0]                       grid_word
);

	logic [`DBG_NUM_PROBES-1:0][`DBG_WORD_W-1:0] bank_q;

	////////////////////////////////////////////////////////////////////
	// Snapshot registers
	////////////////////////////////////////////////////////////////////

	// All probes captured on the same edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			bank_q <= '0;
		else if (snap)
			bank_q <= probe_word;
	end

	////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////

	function automatic logic [`DBG_WORD_W-1:0] read_word(
		input logic [`DBG_NUM_PROBES-1:0][`DBG_WORD_W-1:0] bank,
		input probe_idx_t                                   idx
	);
		logic [`DBG_WORD_W-1:0] word;
		word = bank[idx];
		return word;
	endfunction

	// LED page
	always_comb begin
		led_word = read_word(bank_q, led_idx);
	end

	// Character grid
	always_comb begin
		grid_word = read_word(bank_q, grid_idx);
	end

endmodule

`default_nettype wire

// File: source/dbg_probe_pkg.sv
`default_nettype none

`include "dbg_defines.svh"

package dbg_probe_pkg;

	////////////////////////////////////////////////////////////////////
	// Snapshot control
	////////////////////////////////////////////////////////////////////

	// Run, hold and single step
	typedef enum logic [1:0] {
		RUN       = 2'd0,
		HOLD      = 2'd1,
		STEP_WAIT = 2'd2
	} monitor_state_e;

	////////////////////////////////////////////////////////////////////
	// Probe addressing
	////////////////////////////////////////////////////////////////////

	localparam int PROBE_IDX_W = $clog2(`DBG_NUM_PROBES);

	// Index into the snapshot bank
	typedef logic [PROBE_IDX_W-1:0] probe_idx_t;

endpackage

`default_nettype wire

// File: source/dbg_scan_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_scan_timer import dbg_video_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	output logic      cell_tick,
	output grid_row_t scan_row,
	output grid_col_t scan_col,
	output logic      frame_start
);

	localparam int DIV_W = (`DBG_CELL_DIV > 1) ? $clog2(`DBG_CELL_DIV) : 1;

	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`DBG_CELL_DIV - 1);
	localparam grid_col_t LAST_COL = grid_col_t'(`DBG_GRID_COLS - 1);
	localparam grid_row_t LAST_ROW = grid_row_t'(`DBG_GRID_ROWS - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             last_col;
	logic             last_row;

	////////////////////////////////////////////////////////////////////
	// Cell tick divider
	////////////////////////////////////////////////////////////////////

	assign cell_tick = (div_cnt == DIV_LAST);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			div_cnt <= '0;
		else if (cell_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////
	// Row and column scan
	////////////////////////////////////////////////////////////////////

	assign last_col = (scan_col == LAST_COL);
	assign last_row = (scan_row == LAST_ROW);

	// The tick that leaves the last cell enters row 0, column 0
	assign frame_start = cell_tick && last_col && last_row;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan_row <= '0;
			scan_col <= '0;
		end else if (cell_tick) begin
			if (last_col) begin
				scan_col <= '0;
				scan_row <= last_row ? '0 : scan_row + 1'b1;
			end else begin
				scan_col <= scan_col + 1'b1;
			end
		end
	end

	a_frame_on_tick: assert property (@(posedge clk) disable iff (!arst_n)
		frame_start |-> cell_tick ##1 (scan_row == '0 && scan_col == '0));

endmodule

`default_nettype wire

// File: source/dbg_video_pkg.sv
`default_nettype none

`include "dbg_defines.svh"

package dbg_video_pkg;

	// What a grid cell shows, decoded by the renderer
	typedef enum logic [1:0] {
		CELL_SPACE  = 2'd0,
		CELL_HEADER = 2'd1,
		CELL_PROBE  = 2'd2
	} cell_kind_e;

	////////////////////////////////////////////////////////////////////
	// Grid coordinates
	////////////////////////////////////////////////////////////////////

	localparam int GRID_COL_W = $clog2(`DBG_GRID_COLS);
	localparam int GRID_ROW_W = $clog2(`DBG_GRID_ROWS);

	typedef logic [GRID_COL_W-1:0] grid_col_t;
	typedef logic [GRID_ROW_W-1:0] grid_row_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+source
source/dbg_probe_pkg.sv
source/dbg_video_pkg.sv
source/dbg_monitor_fsm.sv
source/dbg_scan_timer.sv
source/dbg_probe_bank.sv
source/dbg_led_select.sv
source/dbg_cell_render.sv
source/dbg_monitor_top.sv
verif/tb_dbg_monitor.sv

// File: verif/tb_dbg_monitor.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defines.svh"

module tb_dbg_monitor
	import dbg_probe_pkg::*;
	import dbg_video_pkg::*;
();

	localparam int FRAME_CYCLES = `DBG_GRID_COLS * `DBG_GRID_ROWS * `DBG_CELL_DIV;
	// Nine frames of tests and a spare one
	localparam int MAX_CYCLES = 10 * FRAME_CYCLES;
	localparam int CELLS_PER_FRAME = `DBG_GRID_COLS * `DBG_GRID_ROWS;
	localparam int LAST_ROW = `DBG_GRID_ROWS - 1;
	localparam int LAST_COL = `DBG_GRID_COLS - 1;

	logic                                         clk;
	logic                                         arst_n;
	logic [15:0]                                  sw;
	logic                                         freeze;
	logic                                         step;
	logic [`DBG_NUM_PROBES-1:0][`DBG_WORD_W-1:0] probe_word;
	logic [15:0]                                  led_data;
	logic                                         cell_valid;
	grid_row_t                                    cell_row;
	grid_col_t                                    cell_col;
	logic                                         vga_space;
	logic [3:0]                                   vga_data;
	logic                                         frame_start;
	logic                                         frozen;

	logic [`DBG_NUM_PROBES-1:0][`DBG_WORD_W-1:0] model_bank;
	monitor_state_e m_state;
	monitor_state_e m_next;
	logic [15:0]    exp_led_q;
	logic           exp_frozen_q;
	logic           armed;
	logic           fs_q;
	logic [31:0]    lfsr;
	int             cycles;
	int             check_count;
	int             error_count;
	int             err_mark;
	int             cell_count;
	int             cell_mark;
	int             exp_row;
	int             exp_col;

	dbg_monitor_top dut_i (.*);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////
	// Stimulus helpers and reference model
	////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'hD0000001;
		return n;
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic load_probes();
		logic [31:0] v;
		@(posedge clk);
		for (int i = 0; i < `DBG_NUM_PROBES; i++) begin
			take_bits(`DBG_WORD_W, v);
			probe_word[i] <= v[`DBG_WORD_W-1:0];
		end
	endtask

	task automatic wait_frame();
		@(posedge clk);
		while (frame_start !== 1'b1)
			@(posedge clk);
	endtask

	// Expected {space, nibble} for a grid cell
	function automatic logic [4:0] expected_cell(input int row, input int col,
		input logic [`DBG_NUM_PROBES-1:0][`DBG_WORD_W-1:0] bank);
		int          slot;
		int          nib;
		logic [15:0] word;
		slot = (col / 8) % 16;
		nib  = col % 4;
		if (col >= 128 || (col / 4) % 2 == 1)
			return 5'h10;
		if (row == 0)
			return (nib == 3) ? {1'b0, 4'(slot)} : 5'h00;
		if (row > 4)
			return 5'h10;
		word = bank[(row - 1) * 16 + slot];
		return {1'b0, 4'(word >> (12 - 4 * nib))};
	endfunction

	function automatic logic [15:0] expected_led(input logic [15:0] sw_val,
		input logic [`DBG_NUM_PROBES-1:0][`DBG_WORD_W-1:0] bank);
		if (sw_val[15:8] < `DBG_NUM_PROBES)
			return bank[sw_val[13:8]];
		return sw_val;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, actual,
				expected);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s done, %0d errors", name, error_count - err_mark);
		err_mark = error_count;
	endtask

	////////////////////////////////////////////////////////////////////
	// Model snapshot and comparison
	////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!arst_n) begin
			m_state      <= RUN;
			model_bank   <= '0;
			exp_led_q    <= '0;
			exp_frozen_q <= 1'b0;
			armed        <= 1'b0;
		end else begin
			armed     <= 1'b1;
			exp_led_q <= expected_led(sw, model_bank);
			if (frame_start && m_state != HOLD)
				model_bank <= probe_word;
			m_next = m_state;
			case (m_state)
				RUN:       m_next = freeze ? HOLD : RUN;
				HOLD:      m_next = !freeze ? RUN : (step ? STEP_WAIT : HOLD);
				STEP_WAIT: m_next = frame_start ? HOLD : STEP_WAIT;
				default:   m_next = RUN;
			endcase
			m_state      <= m_next;
			exp_frozen_q <= (m_next != RUN);
		end
	end

	always @(posedge clk) begin
		fs_q <= frame_start;
		if (arst_n && armed) begin
			check_value(led_data, exp_led_q, "led_data");
			check_value(frozen, exp_frozen_q, "frozen");
			// Frame start comes on the tick of the last cell
			check_value(fs_q, cell_valid && exp_row == LAST_ROW && exp_col == LAST_COL,
				"frame_start");
			if (cell_valid) begin
				check_value(cell_row, exp_row, "cell_row");
				check_value(cell_col, exp_col, "cell_col");
				check_value({vga_space, vga_data}, expected_cell(cell_row, cell_col, model_bank),
					$sformatf("cell row %0d col %0d", cell_row, cell_col));
				cell_count++;
				if (exp_col == LAST_COL) begin
					exp_col = 0;
					exp_row = (exp_row == LAST_ROW) ? 0 : exp_row + 1;
				end else begin
					exp_col = exp_col + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] v;
		clk        = 1'b0;
		arst_n     = 1'b0;
		sw         = '0;
		freeze     = 1'b0;
		step       = 1'b0;
		probe_word = '0;
		lfsr       = 32'h407ac1d1;
		exp_row    = 0;
		exp_col    = 0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		@(posedge clk);
		check_value(led_data, 16'h0, "led_data after reset");
		check_value(vga_space, 1'b0, "vga_space after reset");
		check_value(cell_valid, 1'b0, "cell_valid after reset");
		check_value(frozen, 1'b0, "frozen after reset");
		check_value(frame_start, 1'b0, "frame_start after reset");
		end_test("reset");

		// Snapshot at the first frame start, then one full frame
		load_probes();
		wait_frame();
		cell_mark = cell_count;
		wait_frame();
		check_value(cell_count - cell_mark, CELLS_PER_FRAME, "cells in one frame");
		end_test("run frame");

		// Even pages hit the bank, odd pages echo the switches
		for (int i = 0; i < 32; i++) begin
			take_bits(16, v);
			if (i % 2 == 0)
				v[15:14] = 2'b00;
			else
				v[14] = 1'b1;
			if (i == 1)
				v[15:8] = 8'd64;
			@(posedge clk);
			sw <= v[15:0];
			@(posedge clk);
		end
		end_test("led pages");

		// Bank page, so held words also show on the LEDs
		take_bits(16, v);
		v[15:14] = 2'b00;
		@(posedge clk);
		sw     <= v[15:0];
		freeze <= 1'b1;
		repeat (2) @(posedge clk);
		load_probes();
		repeat (3) wait_frame();
		check_value(frozen, 1'b1, "frozen while held");
		end_test("freeze");

		@(posedge clk);
		step <= 1'b1;
		@(posedge clk);
		step <= 1'b0;
		wait_frame();
		// New words arrive after the step snapshot
		load_probes();
		wait_frame();
		check_value(frozen, 1'b1, "frozen after step");
		@(posedge clk);
		freeze <= 1'b0;
		wait_frame();
		wait_frame();
		end_test("step");

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
